// File: rename_config.svh
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// architectural register count
`define NUM_REGS 16

// reorder buffer entries, power of two
`define ROB_DEPTH 8

// operand width in bits
`define DATA_WIDTH 32

`endif

// File: renamePkg.sv
`include "rename_config.svh"

package renamePkg;

    // register number
    typedef logic [$clog2(`NUM_REGS)-1:0] regAddrT;

    // index into the reorder buffer
    typedef logic [$clog2(`ROB_DEPTH)-1:0] robTagT;

    // operand and result value
    typedef logic [`DATA_WIDTH-1:0] dataT;

    // life of one ROB entry
    typedef enum logic [1:0] {
        robEmpty,   // free slot
        robIssued,  // allocated, waiting on CDB
        robDone     // result present, may retire
    } robStateT;

endpackage

// File: commitBus.sv
interface commitBus;

    logic              valid;    // head is retiring this cycle
    renamePkg::robTagT tag;      // tag being freed
    renamePkg::regAddrT destReg; // architectural destination
    renamePkg::dataT   value;    // committed result

    modport source (
        output valid,
        output tag,
        output destReg,
        output value
    );

    modport sink (
        input valid,
        input tag,
        input destReg,
        input value
    );

endinterface

// File: registerResultStatus.sv
`include "rename_config.svh"

module registerResultStatus (
    input  logic               CLK,
    input  logic               Reset,
    input  renamePkg::regAddrT queryA,
    input  renamePkg::regAddrT queryB,
    input  logic               append,
    input  renamePkg::regAddrT appendReg,
    input  renamePkg::robTagT  appendTag,
    commitBus.sink             retire,
    output logic               busyA,
    output logic               busyB,
    output renamePkg::robTagT  tagA,
    output renamePkg::robTagT  tagB
);

    logic [`NUM_REGS-1:0] busy;              // register waits on a ROB entry
    renamePkg::robTagT    tagOf [`NUM_REGS]; // producing entry per register

    // two lookups, same cycle
    always_comb begin
        busyA = busy[queryA];
        tagA  = tagOf[queryA];
        busyB = busy[queryB];
        tagB  = tagOf[queryB];
    end

    // A retirement clears every register still naming the retiring tag.
    // Registers renamed to a younger tag keep their busy bit, and an
    // append in the same cycle is applied last so the new writer wins.
    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            busy <= '0;
        end else begin
            if (retire.valid) begin
                for (int i = 0; i < `NUM_REGS; i++) begin
                    if (tagOf[i] == retire.tag) begin
                        busy[i] <= 1'b0;
                    end
                end
            end
            if (append) begin
                busy[appendReg] <= 1'b1; // overrides the clear above
            end
        end
    end

    // producing tag, written on append
    always_ff @(posedge CLK) begin
        if (append) begin
            tagOf[appendReg] <= appendTag;
        end
    end

endmodule

// File: reorderBuffer.sv
`include "rename_config.svh"

module reorderBuffer (
    input  logic               CLK,
    input  logic               Reset,
    input  logic               allocate,
    input  renamePkg::regAddrT allocReg,
    input  logic               cdbValid,
    input  renamePkg::robTagT  cdbTag,
    input  renamePkg::dataT    cdbValue,
    input  renamePkg::robTagT  fwdTagA,
    input  renamePkg::robTagT  fwdTagB,
    output logic               full,
    output renamePkg::robTagT  tailTag,
    output logic               fwdDoneA,
    output logic               fwdDoneB,
    output renamePkg::dataT    fwdValueA,
    output renamePkg::dataT    fwdValueB,
    commitBus.source           retire
);

    localparam int CountW = $clog2(`ROB_DEPTH) + 1;

    renamePkg::robStateT state   [`ROB_DEPTH];
    renamePkg::regAddrT  destOf  [`ROB_DEPTH]; // destination per entry
    renamePkg::dataT     valueOf [`ROB_DEPTH]; // result per entry

    renamePkg::robTagT   head;
    renamePkg::robTagT   tail;
    logic [CountW-1:0]   count;                // live entries
    logic                headDone;

    assign full    = (count == CountW'(`ROB_DEPTH));
    assign tailTag = tail;

    // forward a finished result to a waiting source
    assign fwdDoneA  = (state[fwdTagA] == renamePkg::robDone);
    assign fwdDoneB  = (state[fwdTagB] == renamePkg::robDone);
    assign fwdValueA = valueOf[fwdTagA];
    assign fwdValueB = valueOf[fwdTagB];

    // in-order retire from the head
    assign headDone       = (state[head] == renamePkg::robDone);
    assign retire.valid   = headDone;
    assign retire.tag     = head;
    assign retire.destReg = destOf[head];
    assign retire.value   = valueOf[head];

    // control state: entry states and pointers
    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                state[i] <= renamePkg::robEmpty;
            end
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (headDone) begin
                state[head] <= renamePkg::robEmpty;
                head        <= head + 1'b1; // wraps at depth
            end
            // only an issued entry can complete
            if (cdbValid && state[cdbTag] == renamePkg::robIssued) begin
                state[cdbTag] <= renamePkg::robDone;
            end
            if (allocate) begin
                state[tail] <= renamePkg::robIssued;
                tail        <= tail + 1'b1;
            end
            case ({allocate, headDone})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // entry payload
    always_ff @(posedge CLK) begin
        if (allocate) begin
            destOf[tail] <= allocReg;
        end
        if (cdbValid && state[cdbTag] == renamePkg::robIssued) begin
            valueOf[cdbTag] <= cdbValue;
        end
    end

endmodule

// File: registerFile.sv
`include "rename_config.svh"

module registerFile (
    input  logic               CLK,
    input  logic               Reset,
    input  renamePkg::regAddrT readA,
    input  renamePkg::regAddrT readB,
    commitBus.sink             retire,
    output renamePkg::dataT    valueA,
    output renamePkg::dataT    valueB
);

    renamePkg::dataT regs [`NUM_REGS]; // committed state

    // combinational reads, old value during a write
    assign valueA = regs[readA];
    assign valueB = regs[readB];

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (retire.valid) begin
            regs[retire.destReg] <= retire.value;
        end
    end

endmodule

// File: renameCore.sv
module renameCore (
    input  logic               CLK,
    input  logic               Reset,
    input  logic               dispatchValid,
    input  renamePkg::regAddrT dispatchDest,
    input  renamePkg::regAddrT srcA,
    input  renamePkg::regAddrT srcB,
    input  logic               cdbValid,
    input  renamePkg::robTagT  cdbTag,
    input  renamePkg::dataT    cdbValue,
    output logic               dispatchReady,
    output renamePkg::robTagT  dispatchTag,
    output logic               srcABusy,
    output renamePkg::robTagT  srcATag,
    output logic               srcAReady,
    output renamePkg::dataT    srcAValue,
    output logic               srcBBusy,
    output renamePkg::robTagT  srcBTag,
    output logic               srcBReady,
    output renamePkg::dataT    srcBValue,
    output logic               commitValid,
    output renamePkg::robTagT  commitTag,
    output renamePkg::regAddrT commitReg,
    output renamePkg::dataT    commitValue
);

    commitBus commitIf ();

    logic            robFull;
    logic            accept;     // dispatch taken this edge
    logic            fwdDoneA;
    logic            fwdDoneB;
    renamePkg::dataT fwdValueA;
    renamePkg::dataT fwdValueB;
    renamePkg::dataT rfValueA;
    renamePkg::dataT rfValueB;

    assign dispatchReady = !robFull;
    assign accept        = dispatchValid && !robFull;

    registerResultStatus u_status (
        .CLK       (CLK),
        .Reset     (Reset),
        .queryA    (srcA),
        .queryB    (srcB),
        .append    (accept),
        .appendReg (dispatchDest),
        .appendTag (dispatchTag),
        .retire    (commitIf.sink),
        .busyA     (srcABusy),
        .busyB     (srcBBusy),
        .tagA      (srcATag),
        .tagB      (srcBTag)
    );

    reorderBuffer u_rob (
        .CLK       (CLK),
        .Reset     (Reset),
        .allocate  (accept),
        .allocReg  (dispatchDest),
        .cdbValid  (cdbValid),
        .cdbTag    (cdbTag),
        .cdbValue  (cdbValue),
        .fwdTagA   (srcATag),    // status tag picks the entry
        .fwdTagB   (srcBTag),
        .full      (robFull),
        .tailTag   (dispatchTag),
        .fwdDoneA  (fwdDoneA),
        .fwdDoneB  (fwdDoneB),
        .fwdValueA (fwdValueA),
        .fwdValueB (fwdValueB),
        .retire    (commitIf.source)
    );

    registerFile u_regFile (
        .CLK    (CLK),
        .Reset  (Reset),
        .readA  (srcA),
        .readB  (srcB),
        .retire (commitIf.sink),
        .valueA (rfValueA),
        .valueB (rfValueB)
    );

    // ready from the register file when not busy, else from a done ROB entry
    function automatic void resolveSource(
        input  logic            busy,
        input  logic            fwdDone,
        input  renamePkg::dataT rfValue,
        input  renamePkg::dataT fwdValue,
        output logic            ready,
        output renamePkg::dataT value
    );
        ready = !busy || fwdDone;
        value = busy ? fwdValue : rfValue;
    endfunction

    always_comb begin
        resolveSource(srcABusy, fwdDoneA, rfValueA, fwdValueA, srcAReady, srcAValue);
        resolveSource(srcBBusy, fwdDoneB, rfValueB, fwdValueB, srcBReady, srcBValue);
    end

    assign commitValid = commitIf.valid;
    assign commitTag   = commitIf.tag;
    assign commitReg   = commitIf.destReg;
    assign commitValue = commitIf.value;

endmodule

// File: renameCore_properties.sv
`include "rename_config.svh"

module renameCore_properties (
    input logic               CLK,
    input logic               Reset,
    input logic               dispatchValid,
    input logic               dispatchReady,
    input renamePkg::regAddrT dispatchDest,
    input renamePkg::robTagT  dispatchTag,
    input renamePkg::regAddrT srcA,
    input renamePkg::regAddrT srcB,
    input logic               srcABusy, srcBBusy,
    input renamePkg::robTagT  srcATag, srcBTag,
    input logic               srcAReady, srcBReady,
    input renamePkg::dataT    srcAValue, srcBValue,
    input logic               cdbValid,
    input renamePkg::robTagT  cdbTag,
    input renamePkg::dataT    cdbValue,
    input logic               commitValid,
    input renamePkg::robTagT  commitTag,
    input renamePkg::regAddrT commitReg,
    input renamePkg::dataT    commitValue
);

    int                 failCount = 0;           // read by the testbench
    int                 live;                    // dispatched, not yet retired
    logic               accepted;
    logic               commitIsLatest;          // retiring the youngest writer of its reg
    renamePkg::robTagT  nextCommit;
    renamePkg::dataT    cdbValueOf [`ROB_DEPTH];
    renamePkg::regAddrT regOf      [`ROB_DEPTH];
    logic               doneOf     [`ROB_DEPTH];
    renamePkg::robTagT  latestTag  [`NUM_REGS];

    assign accepted       = dispatchValid && dispatchReady;
    assign commitIsLatest = (latestTag[commitReg] == commitTag)
                            && !(accepted && dispatchDest == commitReg);

    task automatic flagFailure(input string what);
        $error("Fail at %0t: %s", $time, what);
        failCount++;
    endtask

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            live       <= 0;
            nextCommit <= '0;
        end else begin
            live <= live + (accepted ? 1 : 0) - (commitValid ? 1 : 0);
            if (commitValid) begin
                nextCommit <= nextCommit + 1'b1; // wraps at depth
            end
            if (cdbValid) begin
                cdbValueOf[cdbTag] <= cdbValue;
                doneOf[cdbTag]     <= 1'b1;
            end
            if (accepted) begin
                regOf[dispatchTag]      <= dispatchDest;
                doneOf[dispatchTag]     <= 1'b0;
                latestTag[dispatchDest] <= dispatchTag;
            end
        end
    end

    assert property (@(posedge CLK) $fell(Reset) |->
        !commitValid && dispatchReady && !srcABusy && srcAReady && srcAValue == '0
        && !srcBBusy && srcBReady && srcBValue == '0) else flagFailure("state after reset");

    assert property (@(posedge CLK) disable iff (Reset) accepted |=>
        srcA != $past(dispatchDest) || (srcABusy && srcATag == $past(dispatchTag)))
        else flagFailure("destination not renamed to the dispatch tag");

    assert property (@(posedge CLK) disable iff (Reset) commitValid |->
        commitTag == nextCommit && commitReg == regOf[commitTag]
        && commitValue == cdbValueOf[commitTag]) else flagFailure("wrong retirement");

    // latest writer gone, committed value visible
    assert property (@(posedge CLK) disable iff (Reset) commitValid && commitIsLatest |=>
        (srcA != $past(commitReg)
         || (!srcABusy && srcAReady && srcAValue == $past(commitValue)))
        && (srcB != $past(commitReg)
         || (!srcBBusy && srcBReady && srcBValue == $past(commitValue))))
        else flagFailure("register not released by its last writer");

    assert property (@(posedge CLK) disable iff (Reset) commitValid && !commitIsLatest |=>
        srcA != $past(commitReg) || (srcABusy && srcATag == latestTag[srcA]))
        else flagFailure("older writer cleared a newer rename");

    assert property (@(posedge CLK) disable iff (Reset) srcABusy && doneOf[srcATag] |->
        srcAReady && srcAValue == cdbValueOf[srcATag]) else flagFailure("source A forward");

    assert property (@(posedge CLK) disable iff (Reset) srcBBusy && doneOf[srcBTag] |->
        srcBReady && srcBValue == cdbValueOf[srcBTag]) else flagFailure("source B forward");

    assert property (@(posedge CLK) disable iff (Reset) dispatchReady == (live != `ROB_DEPTH))
        else flagFailure("dispatchReady does not match ROB occupancy");

    assert property (@(posedge CLK) disable iff (Reset)
        dispatchValid && !dispatchReady && !commitValid |=>
        dispatchTag == $past(dispatchTag)
        && (!$stable(srcA) || (srcABusy == $past(srcABusy) && srcATag == $past(srcATag)))
        && (!$stable(srcB) || (srcBBusy == $past(srcBBusy) && srcBTag == $past(srcBTag))))
        else flagFailure("dispatch into a full ROB changed state");

endmodule

bind renameCore renameCore_properties u_props (.*);

// File: renameCore_tb.sv
`include "rename_config.svh"

module renameCore_tb;

    logic               CLK = 1'b0;
    logic               Reset;
    logic               dispatchValid;
    renamePkg::regAddrT dispatchDest;
    renamePkg::regAddrT srcA;
    renamePkg::regAddrT srcB;
    logic               cdbValid;
    renamePkg::robTagT  cdbTag;
    renamePkg::dataT    cdbValue;
    logic               dispatchReady;
    renamePkg::robTagT  dispatchTag;
    logic               srcABusy, srcBBusy;
    renamePkg::robTagT  srcATag, srcBTag;
    logic               srcAReady, srcBReady;
    renamePkg::dataT    srcAValue, srcBValue;
    logic               commitValid;
    renamePkg::robTagT  commitTag;
    renamePkg::regAddrT commitReg;
    renamePkg::dataT    commitValue;

    logic [31:0]        lfsr = 32'h74322b1f;
    renamePkg::robTagT  pending [$];        // dispatched, no CDB yet
    int                 timeouts = 0;

    renameCore u_dut (.*);

    always #5 CLK = ~CLK;

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] randomBits(input int width);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < width; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    task automatic nextCycle();
        @(posedge CLK);
        #1;
    endtask

    // random dispatch, and a CDB write to any outstanding tag
    task automatic randomCycle(input logic allowDispatch);
        int pick;
        dispatchValid = allowDispatch && (randomBits(1) != 0);
        dispatchDest  = renamePkg::regAddrT'(randomBits(4));
        srcA          = renamePkg::regAddrT'(randomBits(4));
        srcB          = renamePkg::regAddrT'(randomBits(4));
        cdbValid      = 1'b0;
        if (pending.size() > 0 && randomBits(1) != 0) begin
            pick     = int'(randomBits(3)) % pending.size();
            cdbValid = 1'b1;
            cdbTag   = pending[pick];
            cdbValue = randomBits(32);
            pending.delete(pick);
        end
        if (dispatchValid && dispatchReady) begin
            pending.push_back(dispatchTag);
        end
        nextCycle();
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (pending.size() > 0 || commitValid) begin
            if (waited == 200) begin
                $display("Timeout: the ROB did not drain within 200 cycles");
                timeouts++;
                return;
            end
            randomCycle(1'b0);
            waited++;
        end
    endtask

    // fill without completions, then one dispatch against the full ROB
    task automatic fillAndStall();
        int waited;
        waited = 0;
        cdbValid = 1'b0;
        while (dispatchReady) begin
            if (waited == 20) begin
                $display("Timeout: the ROB never reported full");
                timeouts++;
                return;
            end
            dispatchValid = 1'b1;
            dispatchDest  = renamePkg::regAddrT'(randomBits(4));
            srcA          = renamePkg::regAddrT'(randomBits(4));
            pending.push_back(dispatchTag);
            nextCycle();
            waited++;
        end
        srcA = dispatchDest; // youngest rename, busy
        nextCycle();         // dispatch against the full ROB
        dispatchValid = 1'b0;
        nextCycle();         // srcA held through the check cycle
    endtask

    initial begin
        Reset         = 1'b1;
        dispatchValid = 1'b0;
        dispatchDest  = '0;
        srcA          = '0;
        srcB          = '0;
        cdbValid      = 1'b0;
        cdbTag        = '0;
        cdbValue      = '0;
        repeat (2) @(posedge CLK);
        #1;
        Reset = 1'b0;
        repeat (600) randomCycle(1'b1);
        drain();
        fillAndStall();
        drain();
        repeat (100) randomCycle(1'b1);
        drain();
        $display("assertion failures: %0d, timeouts: %0d", u_dut.u_props.failCount, timeouts);
        if (u_dut.u_props.failCount + timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+.
renamePkg.sv
commitBus.sv
registerResultStatus.sv
reorderBuffer.sv
registerFile.sv
renameCore.sv
renameCore_properties.sv
renameCore_tb.sv
